// File: crc_if.sv
interface crc_if;
	import net_hdr_pkg::*;

	// Pulse during the SFD byte
	logic init;
	// Byte currently on txd
	logic [7:0] data;
	logic data_en;
	// High for the four FCS bytes
	logic crc_rd;
	// Complemented FCS, next byte on top
	crc_t crc;

	modport framer (
		output init,
		output data,
		output data_en,
		output crc_rd,
		input crc
	);

	modport engine (
		input init,
		input data,
		input data_en,
		input crc_rd,
		output crc
	);

endinterface

// File: eth_crc32.sv
module eth_crc32 (
	input logic fifo_clk,
	input logic sys_rst,
	crc_if.engine crc
);
	import net_hdr_pkg::*;

	crc_t crc_q;

	// ------------------------------
	// One byte, LSB first
	// ------------------------------
	function automatic crc_t crc_next(input crc_t c, input logic [7:0] d);
		crc_t r;
		r = c ^ {24'd0, d};
		for (int i = 0; i < 8; i++) begin
			if (r[0]) begin
				r = (r >> 1) ^ CRC_POLY_REFL;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	// Init wins over everything; readout shifts the next byte down
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_q <= CRC_INIT;
		end else if (crc.init) begin
			crc_q <= CRC_INIT;
		end else if (crc.crc_rd) begin
			crc_q <= {8'hFF, crc_q[31:8]};
		end else if (crc.data_en) begin
			crc_q <= crc_next(crc_q, crc.data);
		end
	end

	// ------------------------------
	// Result for the framer
	// ------------------------------
	// FCS goes out low byte of the register first, so it sits on top here
	assign crc.crc = ~{crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

endmodule

// File: gmii_tx.sv
module gmii_tx (
	input logic fifo_clk,
	input logic sys_rst,
	input logic board_id,
	input stream_pkg::vid_word_t vid_data,
	input stream_pkg::fill_t vid_fill,
	output logic vid_rd_en,
	input stream_pkg::aud_sample_t aud_data,
	input stream_pkg::fill_t aud_fill,
	output logic aud_rd_en,
	crc_if.framer crc,
	output logic tx_en,
	output logic [7:0] txd
);
	import net_hdr_pkg::*;
	import stream_pkg::*;

	typedef enum logic [3:0] {
		IDLE, PRE, SFD, ETH, IP, UDP, KIND, VIDEO, AUDIO, FCS, IFG
	} state_t;

	state_t state;
	logic [5:0] cnt;
	logic [1:0] byte_sel;
	logic [7:0] txd_q;
	pkt_kind_t kind;
	len16_t ip_len;
	len16_t udp_len;
	logic [19:0] csum_acc;
	logic [15:0] ip_csum;
	logic [47:0] dst_mac_adj;
	logic [47:0] src_mac_adj;
	logic [31:0] dst_ip_adj;
	logic [31:0] src_ip_adj;
	logic [8*ETH_HDR_LEN-1:0] eth_hdr;
	logic [8*IP_HDR_LEN-1:0] ip_hdr;
	logic [8*UDP_HDR_LEN-1:0] udp_hdr;

	// ------------------------------
	// Header fields
	// ------------------------------
	assign dst_mac_adj = {DST_MAC[47:8], DST_MAC[7:0] - {7'd0, board_id}};
	assign src_mac_adj = {SRC_MAC[47:8], SRC_MAC[7:0] + {7'd0, board_id}};
	assign dst_ip_adj = {DST_IP[31:8], DST_IP[7:0] - {7'd0, board_id}};
	assign src_ip_adj = {SRC_IP[31:8], SRC_IP[7:0] + {7'd0, board_id}};

	assign eth_hdr = {dst_mac_adj, src_mac_adj, ETH_TYPE_IPV4};
	assign ip_hdr = {IP_VER_TOS, ip_len, IP_IDENT, IP_FLAGS, IP_TTL, IP_PROTO_UDP,
		ip_csum, src_ip_adj, dst_ip_adj};
	// UDP checksum left at zero
	assign udp_hdr = {UDP_SRC_PORT, UDP_DST_PORT, udp_len, 16'h0000};

	// Pop together with the edge that takes the last byte of an entry
	assign vid_rd_en = (state == VIDEO) && (byte_sel == 2'(VID_WORD_BYTES - 1));
	assign aud_rd_en = (state == AUDIO) && (byte_sel == 2'(AUD_SAMPLE_BYTES - 1));

	// FCS bytes come straight from the engine
	assign txd = crc.crc_rd ? crc.crc[31:24] : txd_q;
	assign crc.data = txd;

	// ------------------------------
	// Frame FSM
	// ------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			cnt <= '0;
			byte_sel <= '0;
			txd_q <= 8'h00;
			tx_en <= 1'b0;
			kind <= KIND_VIDEO;
			crc.init <= 1'b0;
			crc.data_en <= 1'b0;
			crc.crc_rd <= 1'b0;
		end else begin
			crc.init <= 1'b0;
			crc.data_en <= 1'b0;
			crc.crc_rd <= 1'b0;
			case (state)
				IDLE: begin
					cnt <= '0;
					// Video first when both are ready
					if (vid_fill >= fill_t'(VIDEO_WORDS)) begin
						kind <= KIND_VIDEO;
						ip_len <= IP_HDR_LEN + UDP_HDR_LEN + len16_t'(KIND_LEN + VIDEO_BYTES);
						udp_len <= UDP_HDR_LEN + len16_t'(KIND_LEN + VIDEO_BYTES);
						txd_q <= PREAMBLE_BYTE;
						tx_en <= 1'b1;
						state <= PRE;
					end else if (aud_fill >= fill_t'(AUDIO_SAMPLES)) begin
						kind <= KIND_AUDIO;
						ip_len <= IP_HDR_LEN + UDP_HDR_LEN + len16_t'(KIND_LEN + AUDIO_BYTES);
						udp_len <= UDP_HDR_LEN + len16_t'(KIND_LEN + AUDIO_BYTES);
						txd_q <= PREAMBLE_BYTE;
						tx_en <= 1'b1;
						state <= PRE;
					end
				end
				PRE: begin
					txd_q <= PREAMBLE_BYTE;
					// Header checksum: sum, fold, complement
					case (cnt)
						6'd0: csum_acc <= 20'(IP_VER_TOS) + 20'(ip_len) + 20'(IP_IDENT)
							+ 20'(IP_FLAGS) + 20'({IP_TTL, IP_PROTO_UDP})
							+ 20'(src_ip_adj[31:16]) + 20'(src_ip_adj[15:0])
							+ 20'(dst_ip_adj[31:16]) + 20'(dst_ip_adj[15:0]);
						6'd1: csum_acc <= 20'(csum_acc[15:0]) + 20'(csum_acc[19:16]);
						6'd2: ip_csum <= ~(csum_acc[15:0] + {15'd0, csum_acc[16]});
						default: ;
					endcase
					// First preamble byte already went out from IDLE
					if (cnt == 6'(PREAMBLE_LEN - 2)) begin
						cnt <= '0;
						state <= SFD;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				SFD: begin
					txd_q <= SFD_BYTE;
					crc.init <= 1'b1;
					state <= ETH;
				end
				ETH: begin
					txd_q <= eth_hdr[8*(ETH_HDR_LEN-1-cnt) +: 8];
					crc.data_en <= 1'b1;
					if (cnt == 6'(ETH_HDR_LEN - 1)) begin
						cnt <= '0;
						state <= IP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				IP: begin
					txd_q <= ip_hdr[8*(IP_HDR_LEN-1-cnt) +: 8];
					crc.data_en <= 1'b1;
					if (cnt == 6'(IP_HDR_LEN - 1)) begin
						cnt <= '0;
						state <= UDP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				UDP: begin
					txd_q <= udp_hdr[8*(UDP_HDR_LEN-1-cnt) +: 8];
					crc.data_en <= 1'b1;
					if (cnt == 6'(UDP_HDR_LEN - 1)) begin
						cnt <= '0;
						state <= KIND;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				KIND: begin
					txd_q <= kind;
					crc.data_en <= 1'b1;
					byte_sel <= '0;
					state <= (kind == KIND_VIDEO) ? VIDEO : AUDIO;
				end
				VIDEO: begin
					// High byte then low byte of each word
					txd_q <= (byte_sel == 2'd0) ? vid_data[15:8] : vid_data[7:0];
					crc.data_en <= 1'b1;
					byte_sel <= (byte_sel == 2'(VID_WORD_BYTES - 1)) ? 2'd0 : byte_sel + 1'b1;
					if (cnt == 6'(VIDEO_BYTES - 1)) begin
						cnt <= '0;
						state <= FCS;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				AUDIO: begin
					case (byte_sel)
						2'd0: txd_q <= aud_data[23:16];
						2'd1: txd_q <= aud_data[15:8];
						default: txd_q <= aud_data[7:0];
					endcase
					crc.data_en <= 1'b1;
					byte_sel <= (byte_sel == 2'(AUD_SAMPLE_BYTES - 1)) ? 2'd0 : byte_sel + 1'b1;
					if (cnt == 6'(AUDIO_BYTES - 1)) begin
						cnt <= '0;
						state <= FCS;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				FCS: begin
					crc.crc_rd <= 1'b1;
					if (cnt == 6'(FCS_LEN - 1)) begin
						cnt <= '0;
						state <= IFG;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				IFG: begin
					tx_en <= 1'b0;
					txd_q <= 8'h00;
					if (cnt == 6'(IFG_LEN - 1)) begin
						cnt <= '0;
						state <= IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: gmii_tx_top.f
+incdir+.
net_hdr_pkg.sv
stream_pkg.sv
crc_if.sv
eth_crc32.sv
sync_fifo.sv
gmii_tx.sv
gmii_tx_top.sv
tb_gmii_tx_top.sv

// File: gmii_tx_top.sv
module gmii_tx_top (
	input logic fifo_clk,
	input logic sys_rst,
	input logic board_id,
	input logic vid_wr_en,
	input stream_pkg::vid_word_t vid_wr_data,
	output logic vid_full,
	input logic aud_wr_en,
	input stream_pkg::aud_sample_t aud_wr_data,
	output logic aud_full,
	output logic tx_en,
	output logic [7:0] txd
);
	import stream_pkg::*;

	vid_word_t vid_rd_data;
	fill_t vid_fill;
	logic vid_rd_en;
	aud_sample_t aud_rd_data;
	fill_t aud_fill;
	logic aud_rd_en;

	crc_if crc_bus ();

	// ------------------------------
	// Stream buffers
	// ------------------------------
	sync_fifo #(.payload_t(vid_word_t)) u_vid_fifo (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.wr_en    (vid_wr_en),
		.wr_data  (vid_wr_data),
		.full     (vid_full),
		.rd_en    (vid_rd_en),
		.rd_data  (vid_rd_data),
		.empty    (),
		.fill     (vid_fill)
	);

	sync_fifo #(.payload_t(aud_sample_t)) u_aud_fifo (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.wr_en    (aud_wr_en),
		.wr_data  (aud_wr_data),
		.full     (aud_full),
		.rd_en    (aud_rd_en),
		.rd_data  (aud_rd_data),
		.empty    (),
		.fill     (aud_fill)
	);

	// ------------------------------
	// Framer and FCS
	// ------------------------------
	gmii_tx u_framer (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.board_id  (board_id),
		.vid_data  (vid_rd_data),
		.vid_fill  (vid_fill),
		.vid_rd_en (vid_rd_en),
		.aud_data  (aud_rd_data),
		.aud_fill  (aud_fill),
		.aud_rd_en (aud_rd_en),
		.crc       (crc_bus.framer),
		.tx_en     (tx_en),
		.txd       (txd)
	);

	eth_crc32 u_crc (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc      (crc_bus.engine)
	);

endmodule

// File: net_hdr_pkg.sv
package net_hdr_pkg;

	typedef logic [31:0] crc_t;
	typedef logic [15:0] len16_t;

	// ------------------------------
	// Ethernet framing
	// ------------------------------
	localparam int unsigned PREAMBLE_LEN = 7;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	localparam int unsigned ETH_HDR_LEN = 14;
	localparam int unsigned FCS_LEN = 4;
	// Idle cycles with tx_en low between frames
	localparam int unsigned IFG_LEN = 12;

	// Base addresses, low byte moved by board_id
	localparam logic [47:0] DST_MAC = 48'h00_23_45_67_89_02;
	localparam logic [47:0] SRC_MAC = 48'h00_23_45_67_89_01;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

	// ------------------------------
	// IPv4 and UDP
	// ------------------------------
	localparam logic [15:0] IP_VER_TOS = 16'h4500;
	localparam logic [15:0] IP_IDENT = 16'h0000;
	localparam logic [15:0] IP_FLAGS = 16'h4000;
	localparam logic [7:0] IP_TTL = 8'h40;
	localparam logic [7:0] IP_PROTO_UDP = 8'h11;
	localparam logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] DST_IP = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] UDP_SRC_PORT = 16'd12344;
	localparam logic [15:0] UDP_DST_PORT = 16'd12345;
	localparam len16_t IP_HDR_LEN = 16'd20;
	localparam len16_t UDP_HDR_LEN = 16'd8;

	// Reflected form of 0x04C11DB7
	localparam crc_t CRC_POLY_REFL = 32'hEDB88320;
	localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the gmii_tx_top testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_gmii_tx_top \
	-f gmii_tx_top.f -o sim_gmii_tx_top
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/sim_gmii_tx_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0

// File: stream_pkg.sv
package stream_pkg;

	// Video entry: line number first, then luma/chroma pairs
	typedef logic [15:0] vid_word_t;
	// Audio entry: one sample, sent MSB first
	typedef logic [23:0] aud_sample_t;

	typedef enum logic [7:0] {
		KIND_VIDEO = 8'd0,
		KIND_AUDIO = 8'd1
	} pkt_kind_t;

	// ------------------------------
	// Packet sizes
	// ------------------------------
	localparam int unsigned VIDEO_WORDS = 16;
	localparam int unsigned AUDIO_SAMPLES = 10;
	localparam int unsigned VID_WORD_BYTES = 2;
	localparam int unsigned AUD_SAMPLE_BYTES = 3;
	localparam int unsigned VIDEO_BYTES = VIDEO_WORDS * VID_WORD_BYTES;
	localparam int unsigned AUDIO_BYTES = AUDIO_SAMPLES * AUD_SAMPLE_BYTES;
	// Kind byte ahead of the payload
	localparam int unsigned KIND_LEN = 1;

	// ------------------------------
	// FIFO sizing
	// ------------------------------
	localparam int unsigned FIFO_DEPTH = 64;
	localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// Fill count must reach FIFO_DEPTH itself
	typedef logic [$clog2(FIFO_DEPTH + 1) - 1:0] fill_t;

endpackage

// File: sync_fifo.sv
module sync_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input logic fifo_clk,
	input logic sys_rst,
	input logic wr_en,
	input payload_t wr_data,
	output logic full,
	input logic rd_en,
	output payload_t rd_data,
	output logic empty,
	output stream_pkg::fill_t fill
);
	import stream_pkg::*;

	payload_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	// Writes into a full buffer are simply lost
	assign full = (fill == fill_t'(FIFO_DEPTH));
	assign empty = (fill == '0);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head entry visible without a read strobe
	assign rd_data = mem[rd_ptr];

	// ------------------------------
	// Storage
	// ------------------------------
	always_ff @(posedge fifo_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ------------------------------
	// Pointers and count
	// ------------------------------
	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

// File: tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Values accepted by the FIFOs, oldest first
stream_pkg::vid_word_t vid_model_q[$];
stream_pkg::aud_sample_t aud_model_q[$];

// Expected Ethernet, IP and UDP header bytes of the current frame
logic [7:0] exp_hdr[$];

// ------------------------------
// Header builder
// ------------------------------
task automatic build_headers(input logic bid, input pkt_kind_t k);
	logic [47:0] dmac;
	logic [47:0] smac;
	logic [31:0] dip;
	logic [31:0] sip;
	len16_t ip_total;
	len16_t udp_total;
	logic [15:0] words[10];
	logic [31:0] sum;
	logic [15:0] csum;
	int pay;
	pay = (k == KIND_VIDEO) ? VIDEO_WORDS * 2 : AUDIO_SAMPLES * 3;
	dmac = net_hdr_pkg::DST_MAC;
	smac = net_hdr_pkg::SRC_MAC;
	dip = net_hdr_pkg::DST_IP;
	sip = net_hdr_pkg::SRC_IP;
	dmac[7:0] = dmac[7:0] - {7'd0, bid};
	smac[7:0] = smac[7:0] + {7'd0, bid};
	dip[7:0] = dip[7:0] - {7'd0, bid};
	sip[7:0] = sip[7:0] + {7'd0, bid};
	ip_total = len16_t'(20 + 8 + 1 + pay);
	udp_total = len16_t'(8 + 1 + pay);
	// Checksum field counted as zero
	words = '{IP_VER_TOS, ip_total, IP_IDENT, IP_FLAGS, {IP_TTL, IP_PROTO_UDP}, 16'h0000,
		sip[31:16], sip[15:0], dip[31:16], dip[15:0]};
	sum = 32'd0;
	for (int i = 0; i < 10; i++) begin
		sum = sum + {16'd0, words[i]};
	end
	while (sum[31:16] != 16'd0) begin
		sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
	end
	csum = ~sum[15:0];
	words[5] = csum;
	exp_hdr.delete();
	for (int i = 5; i >= 0; i--) begin
		exp_hdr.push_back(dmac[8*i +: 8]);
	end
	for (int i = 5; i >= 0; i--) begin
		exp_hdr.push_back(smac[8*i +: 8]);
	end
	exp_hdr.push_back(ETH_TYPE_IPV4[15:8]);
	exp_hdr.push_back(ETH_TYPE_IPV4[7:0]);
	for (int i = 0; i < 10; i++) begin
		exp_hdr.push_back(words[i][15:8]);
		exp_hdr.push_back(words[i][7:0]);
	end
	exp_hdr.push_back(UDP_SRC_PORT[15:8]);
	exp_hdr.push_back(UDP_SRC_PORT[7:0]);
	exp_hdr.push_back(UDP_DST_PORT[15:8]);
	exp_hdr.push_back(UDP_DST_PORT[7:0]);
	exp_hdr.push_back(udp_total[15:8]);
	exp_hdr.push_back(udp_total[7:0]);
	exp_hdr.push_back(8'h00);
	exp_hdr.push_back(8'h00);
endtask

// ------------------------------
// Reference CRC-32
// ------------------------------
// Bit-serial MSB-first form, bits fed LSB first from each byte
function automatic net_hdr_pkg::crc_t ref_crc32(input logic [7:0] data_q[$]);
	logic [31:0] c;
	logic [31:0] r;
	logic fb;
	c = 32'hFFFF_FFFF;
	foreach (data_q[n]) begin
		for (int b = 0; b < 8; b++) begin
			fb = c[31] ^ data_q[n][b];
			c = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
		end
	end
	for (int b = 0; b < 32; b++) begin
		r[b] = c[31-b];
	end
	return ~r;
endfunction

`endif

// File: tb_gmii_tx_top.sv
module tb_gmii_tx_top;
	import net_hdr_pkg::*;
	import stream_pkg::*;

	localparam int NUM_FRAMES = 40;
	localparam int MAX_FRAME_LEN = 8 + 43 + VIDEO_WORDS * 2 + 4;
	// Four times the longest frame plus gap for each frame
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * (MAX_FRAME_LEN + IFG_LEN) * 4;

	logic fifo_clk;
	logic sys_rst;
	logic board_id;
	logic vid_wr_en;
	vid_word_t vid_wr_data;
	logic vid_full;
	logic aud_wr_en;
	aud_sample_t aud_wr_data;
	logic aud_full;
	logic tx_en;
	logic [7:0] txd;

	integer seed;
	int mismatch_cnt;
	int other_err_cnt;
	int frames_done;
	int low_cnt;
	logic prev_tx_en;
	pkt_kind_t exp_kind;
	logic [7:0] frame_q[$];
	int vid_wr_cnt;
	int vid_wr_prev;
	int vid_pop_cnt;
	int aud_wr_cnt;
	int aud_wr_prev;
	int aud_pop_cnt;

	`include "tb_frame_model.svh"

	gmii_tx_top u_gmii_tx_top (
		.fifo_clk    (fifo_clk),
		.sys_rst     (sys_rst),
		.board_id    (board_id),
		.vid_wr_en   (vid_wr_en),
		.vid_wr_data (vid_wr_data),
		.vid_full    (vid_full),
		.aud_wr_en   (aud_wr_en),
		.aud_wr_data (aud_wr_data),
		.aud_full    (aud_full),
		.tx_en       (tx_en),
		.txd         (txd)
	);

	initial begin
		fifo_clk = 1'b0;
		forever #50 fifo_clk = ~fifo_clk;
	end

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_vid_word(input string name, input vid_word_t got, input vid_word_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_aud_sample(input string name, input aud_sample_t got,
		input aud_sample_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_crc(input string name, input crc_t got, input crc_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// ------------------------------
	// Frame checker
	// ------------------------------
	task automatic check_frame();
		int pay;
		int n;
		logic [7:0] crc_bytes[$];
		crc_t c;
		n = frame_q.size();
		if (n < 51) begin
			other_err_cnt++;
			$display("frame %0d ended after only %0d bytes", frames_done, n);
			return;
		end
		for (int i = 0; i < 7; i++) begin
			check_byte($sformatf("frame %0d preamble %0d", frames_done, i), frame_q[i], 8'h55);
		end
		check_byte($sformatf("frame %0d sfd", frames_done), frame_q[7], SFD_BYTE);
		check_byte($sformatf("frame %0d kind", frames_done), frame_q[50], exp_kind);
		if (exp_kind == KIND_VIDEO) begin
			pay = VIDEO_WORDS * 2;
		end else begin
			pay = AUDIO_SAMPLES * 3;
		end
		if (n != 8 + 43 + pay + 4) begin
			other_err_cnt++;
			$display("frame %0d has %0d bytes instead of %0d", frames_done, n, 8 + 43 + pay + 4);
			return;
		end
		build_headers(board_id, exp_kind);
		for (int i = 0; i < 42; i++) begin
			check_byte($sformatf("frame %0d header byte %0d", frames_done, i),
				frame_q[8 + i], exp_hdr[i]);
		end
		// Payload rebuilt entry by entry against the oldest model values
		if (exp_kind == KIND_VIDEO) begin
			for (int w = 0; w < VIDEO_WORDS; w++) begin
				if (vid_model_q.size() == 0) begin
					other_err_cnt++;
					$display("frame %0d carries more video words than were written", frames_done);
					break;
				end
				check_vid_word($sformatf("frame %0d video word %0d", frames_done, w),
					{frame_q[51 + 2*w], frame_q[52 + 2*w]}, vid_model_q.pop_front());
			end
			vid_pop_cnt += VIDEO_WORDS;
		end else begin
			for (int s = 0; s < AUDIO_SAMPLES; s++) begin
				if (aud_model_q.size() == 0) begin
					other_err_cnt++;
					$display("frame %0d carries more audio samples than were written", frames_done);
					break;
				end
				check_aud_sample($sformatf("frame %0d audio sample %0d", frames_done, s),
					{frame_q[51 + 3*s], frame_q[52 + 3*s], frame_q[53 + 3*s]},
					aud_model_q.pop_front());
			end
			aud_pop_cnt += AUDIO_SAMPLES;
		end
		for (int i = 8; i < n - 4; i++) begin
			crc_bytes.push_back(frame_q[i]);
		end
		c = ref_crc32(crc_bytes);
		// Low byte of the CRC goes on the wire first
		check_crc($sformatf("frame %0d fcs", frames_done),
			{frame_q[n-4], frame_q[n-3], frame_q[n-2], frame_q[n-1]},
			{c[7:0], c[15:8], c[23:16], c[31:24]});
	endtask

	// ------------------------------
	// Output monitor run on each falling edge
	// ------------------------------
	task automatic sample_outputs();
		logic vid_ready;
		logic aud_ready;
		if (tx_en) begin
			if (!prev_tx_en) begin
				if (frames_done > 0 && low_cnt < IFG_LEN) begin
					other_err_cnt++;
					$display("gap before frame %0d lasted only %0d cycles", frames_done, low_cnt);
				end
				// Fill the FIFOs showed at the edge that started the frame
				vid_ready = (vid_wr_prev - vid_pop_cnt) >= VIDEO_WORDS;
				aud_ready = (aud_wr_prev - aud_pop_cnt) >= AUDIO_SAMPLES;
				if (!vid_ready && !aud_ready) begin
					other_err_cnt++;
					$display("frame %0d started while neither FIFO held a full packet", frames_done);
				end
				exp_kind = vid_ready ? KIND_VIDEO : KIND_AUDIO;
				frame_q.delete();
			end
			frame_q.push_back(txd);
		end else begin
			if (prev_tx_en) begin
				check_frame();
				frames_done++;
				low_cnt = 0;
			end
			low_cnt++;
			check_flag("vid_full", vid_full, (vid_wr_cnt - vid_pop_cnt) == FIFO_DEPTH);
			check_flag("aud_full", aud_full, (aud_wr_cnt - aud_pop_cnt) == FIFO_DEPTH);
		end
		prev_tx_en = tx_en;
	endtask

	// Write rates in sixteenths that change every ten frames
	task automatic drive_writes();
		int phase;
		int vid_thr;
		int aud_thr;
		logic [31:0] r;
		phase = frames_done / 10;
		case (phase)
			0: begin
				vid_thr = 8;
				aud_thr = 8;
			end
			1: begin
				vid_thr = 0;
				aud_thr = 6;
			end
			2: begin
				vid_thr = 2;
				aud_thr = 2;
			end
			default: begin
				vid_thr = 5;
				aud_thr = 5;
			end
		endcase
		r = $random(seed);
		vid_wr_prev = vid_wr_cnt;
		aud_wr_prev = aud_wr_cnt;
		vid_wr_en = (int'(r[3:0]) < vid_thr);
		aud_wr_en = (int'(r[7:4]) < aud_thr);
		vid_wr_data = vid_word_t'($random(seed));
		aud_wr_data = aud_sample_t'($random(seed));
		// Writes into a full FIFO are driven but never enter the model
		if (vid_wr_en && !vid_full) begin
			vid_model_q.push_back(vid_wr_data);
			vid_wr_cnt++;
		end
		if (aud_wr_en && !aud_full) begin
			aud_model_q.push_back(aud_wr_data);
			aud_wr_cnt++;
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		logic [31:0] r;
		seed = 32'h8784b042;
		sys_rst = 1'b1;
		vid_wr_en = 1'b0;
		vid_wr_data = '0;
		aud_wr_en = 1'b0;
		aud_wr_data = '0;
		mismatch_cnt = 0;
		other_err_cnt = 0;
		frames_done = 0;
		low_cnt = 0;
		prev_tx_en = 1'b0;
		exp_kind = KIND_VIDEO;
		vid_wr_cnt = 0;
		vid_wr_prev = 0;
		vid_pop_cnt = 0;
		aud_wr_cnt = 0;
		aud_wr_prev = 0;
		aud_pop_cnt = 0;
		r = $random(seed);
		board_id = r[0];
		repeat (2) @(posedge fifo_clk);
		@(negedge fifo_clk);
		sys_rst = 1'b0;
		while (frames_done < NUM_FRAMES) begin
			@(negedge fifo_clk);
			sample_outputs();
			drive_writes();
		end
		vid_wr_en = 1'b0;
		aud_wr_en = 1'b0;
		$display("errors: mismatches %0d, other %0d", mismatch_cnt, other_err_cnt);
		if (mismatch_cnt == 0 && other_err_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * 100);
		$display("timeout after %0d cycles with %0d of %0d frames seen",
			WATCHDOG_CYCLES, frames_done, NUM_FRAMES);
		$display("errors: mismatches %0d, other %0d", mismatch_cnt, other_err_cnt + 1);
		$display("Verification failed");
		$finish;
	end

endmodule
